// File: bench/clock_gen.sv
// Testbench clock and reset source: 40 ns clock, reset held for 8 rising edges
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    input  wire  reset_req,                     // Restart the reset sequence
    output logic clk,
    output logic reset
);

    localparam int RESET_CYCLES = 8;

    int cycles_done = 0;                        // Rising edges seen in reset

    always begin
        clk = 1'b0;
        #20;                                    // Half of the 40 ns period
        clk = 1'b1;
        #20;
    end

    always @(posedge clk) begin
        if (reset_req)
            cycles_done <= 0;
        else if (cycles_done < RESET_CYCLES)
            cycles_done <= cycles_done + 1;
    end

    assign reset = (cycles_done < RESET_CYCLES);

endmodule

`default_nettype wire

// File: bench/tb_rom_loader.sv
// ROM loader testbench with directed download tests against an SDRAM sink model
`timescale 1ns/1ps
`default_nettype none

module tb_rom_loader;

    localparam int TIMEOUT_CYCLES = 20000;      // Tests need about 2000 cycles
    localparam int READY_HIGH     = 0;
    localparam int READY_RANDOM   = 1;
    localparam int READY_LOW      = 2;          // Sink fully stalled
    localparam logic [21:0] BULK_ADDRS [10] = '{22'h000000, 22'h000001, 22'h012345,
        22'h027ffe, 22'h030003, 22'h048000, 22'h048001, 22'h050000, 22'h05abcd, 22'h097fff};
    localparam logic [14:0] SND_OFFS [4] = '{15'h0000, 15'h0001, 15'h1234, 15'h7fff};

    logic        clk, reset, reset_req;
    logic [21:0] ioctl_addr, prog_addr;
    logic [7:0]  ioctl_data, prog_data, prom_rd_addr, prom_rd_data, snd_rd_data;
    logic        ioctl_wr, ioctl_ready, prog_valid, prog_ready;
    logic [1:0]  prog_mask;
    logic [3:0]  prom_rd_sel;
    logic [14:0] snd_rd_addr;
    logic [31:0] got_q [$];                     // {addr, data, mask} seen at the port
    logic [31:0] exp_q [$];
    int          got_rd, errors, checks, ready_mode;
    int          cycles = 0;
    bit          ready_rnd = 1'b1;
    bit          saw_stall;
    string       test_name;

    clock_gen u_clock (.reset_req(reset_req), .clk(clk), .reset(reset));

    rom_loader_top #(.QUEUE_DEPTH(4), .SND_AW(15)) i_rom_loader_top (
        .clk(clk), .reset(reset), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
        .ioctl_wr(ioctl_wr), .ioctl_ready(ioctl_ready), .prog_addr(prog_addr),
        .prog_data(prog_data), .prog_mask(prog_mask), .prog_valid(prog_valid),
        .prog_ready(prog_ready), .prom_rd_sel(prom_rd_sel), .prom_rd_addr(prom_rd_addr),
        .prom_rd_data(prom_rd_data), .snd_rd_addr(snd_rd_addr), .snd_rd_data(snd_rd_data)
    );

    // SDRAM sink logs every handshake
    always @(posedge clk) begin
        if (prog_valid && prog_ready)
            got_q.push_back({prog_addr, prog_data, prog_mask});
    end

    always @(negedge clk) ready_rnd <= 1'($urandom_range(1, 0));
    assign prog_ready = (ready_mode == READY_RANDOM) ? ready_rnd : (ready_mode == READY_HIGH);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, test %s did not finish", cycles, test_name);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", test_name, expected, actual);
        end
    endtask

    // Expected SDRAM write of one download byte or 0 for on-chip regions
    function automatic bit expected_write(input logic [21:0] a, output logic [21:0] waddr,
                                          output logic [1:0] mask);
        logic [21:0] off;
        logic        lane;
        waddr = '0;
        lane  = 1'b0;
        mask  = 2'b11;
        if (a >= rom_load_pkg::SND_START && a < rom_load_pkg::CHAR_START)
            return 1'b0;                        // Sound ROM
        if (a >= rom_load_pkg::ROM_END)
            return 1'b0;                        // PROMs
        if (a < rom_load_pkg::MAP_START) begin
            waddr = a >> 1;
            lane  = a[0];
        end else if (a < rom_load_pkg::SCR_START) begin
            off   = a - rom_load_pkg::MAP_START;
            waddr = (rom_load_pkg::MAP_START >> 1) + (((off >> 5) << 4)
                    | (((off >> 1) & 22'h7) << 1) | ((off >> 4) & 22'h1));
            lane  = off[0];
        end else begin
            off   = a - rom_load_pkg::SCR_START;
            lane  = off[15];
            if (a < rom_load_pkg::OBJ_START)    // Scroll drops bit 15
                waddr = (rom_load_pkg::SCR_START >> 1) + (((off >> 16) << 15) | (off & 22'h7fff));
            else                                // Object moves bit 5 below bits 4..1
                waddr = (rom_load_pkg::SCR_START >> 1) + (((off >> 16) << 15)
                        | (off & 22'h7fc0) | (((off >> 1) & 22'hf) << 2)
                        | (((off >> 5) & 22'h1) << 1) | (off & 22'h1));
        end
        mask = lane ? 2'b01 : 2'b10;            // Enabled lane is 0
        return 1'b1;
    endfunction

    function automatic logic [7:0] prom_offset(input int s, input int k);
        return (k == 0) ? 8'(s * 7 + 3) : 8'(255 - s);
    endfunction

    function automatic logic [7:0] prom_byte(input int s, input int k);
        return 8'(s * 16 + 5 + k * 5);
    endfunction

    task automatic prog_ready_mode(input int mode);
        ready_mode = mode;
    endtask

    // Drives one byte from a falling edge and holds it until the loader takes it
    task automatic send_byte(input logic [21:0] addr, input logic [7:0] data);
        ioctl_addr = addr;
        ioctl_data = data;
        ioctl_wr   = 1'b1;
        while (!ioctl_ready) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        @(negedge clk);                         // Taken on the edge just passed
        ioctl_wr = 1'b0;
    endtask

    task automatic load_byte(input logic [21:0] addr, input logic [7:0] data);
        logic [21:0] waddr;
        logic [1:0]  mask;
        if (expected_write(addr, waddr, mask))
            exp_q.push_back({waddr, data, mask});
        send_byte(addr, data);
    endtask

    // All expected writes in order and nothing extra
    task automatic check_writes();
        while (got_q.size() - got_rd < exp_q.size())
            @(negedge clk);
        repeat (8) @(negedge clk);
        check_value(exp_q.size(), got_q.size() - got_rd);
        while (exp_q.size() > 0 && got_rd < got_q.size()) begin
            check_value(exp_q.pop_front(), got_q[got_rd]);
            got_rd++;
        end
        exp_q.delete();
        got_rd = got_q.size();
    endtask

    task automatic main_scroll_lanes();
        test_name = "main_scroll";
        for (int i = 0; i < 10; i++)
            load_byte(BULK_ADDRS[i], BULK_ADDRS[i][7:0] ^ 8'(i * 29));
        check_writes();
    endtask

    task automatic map_obj_reorder();
        test_name = "map_obj";
        load_byte(rom_load_pkg::MAP_START + 22'hffff, 8'h7e);
        for (int b = 0; b < 16; b++)                        // One moved bit at a time
            load_byte(rom_load_pkg::MAP_START + (22'h1 << b), 8'(b + 16));
        for (int b = 0; b < 19; b++)
            load_byte(rom_load_pkg::SCR_START + (22'h50000 | (22'h1 << b)), 8'(b + 64));
        load_byte(rom_load_pkg::SCR_START + 22'h8ffff, 8'h99);
        check_writes();
    endtask

    task automatic sound_readback();
        test_name = "sound";
        for (int i = 0; i < 4; i++)
            load_byte(rom_load_pkg::SND_START + 22'(SND_OFFS[i]), 8'(i * 37 + 11));
        check_writes();                                     // Expects no SDRAM write
        for (int i = 0; i < 4; i++) begin
            snd_rd_addr = SND_OFFS[i];
            @(posedge clk);
            check_value(8'(i * 37 + 11), snd_rd_data);
            @(negedge clk);
        end
    endtask

    task automatic all_prom_selects();
        test_name = "prom";
        for (int s = 0; s < 12; s++)
            for (int k = 0; k < 2; k++)
                load_byte(rom_load_pkg::ROM_END | (22'(s) << 8) | 22'(prom_offset(s, k)),
                          prom_byte(s, k));
        load_byte(rom_load_pkg::ROM_END | (22'd13 << 8) | 22'(prom_offset(0, 0)), 8'hee);
        load_byte(rom_load_pkg::ROM_END | (22'd13 << 8) | 22'(prom_offset(0, 1)), 8'hee);
        check_writes();
        for (int s = 0; s < 12; s++)
            for (int k = 0; k < 2; k++) begin
                prom_rd_sel  = 4'(s);
                prom_rd_addr = prom_offset(s, k);
                @(posedge clk);
                check_value(prom_byte(s, k), prom_rd_data);
                @(negedge clk);
            end
    endtask

    task automatic random_backpressure();
        logic [21:0] addr;
        test_name = "backpressure";
        prog_ready_mode(READY_RANDOM);
        saw_stall = 1'b0;
        for (int i = 0; i < 200; i++) begin
            case ($urandom_range(3, 0))
                0:       addr = 22'($urandom_range(32'h27fff, 0));
                1:       addr = rom_load_pkg::MAP_START + 22'($urandom_range(32'hffff, 0));
                2:       addr = rom_load_pkg::SCR_START + 22'($urandom_range(32'h4ffff, 0));
                default: addr = rom_load_pkg::OBJ_START + 22'($urandom_range(32'h3ffff, 0));
            endcase
            load_byte(addr, 8'($urandom));
        end
        check_value(1, saw_stall);
        check_writes();
        prog_ready_mode(READY_HIGH);
    endtask

    // Reset with a full queue and a held write
    task automatic reset_flush();
        test_name = "reset";
        prog_ready_mode(READY_LOW);
        for (int i = 0; i < 5; i++)
            send_byte(22'h000100 + 22'(i), 8'(i));
        check_value(1, prog_valid);
        check_value(0, ioctl_ready);
        reset_req = 1'b1;
        @(negedge clk);
        reset_req = 1'b0;
        while (reset)
            @(negedge clk);
        check_value(0, prog_valid);
        check_value(1, ioctl_ready);
        prog_ready_mode(READY_HIGH);
        check_writes();                                     // Flushed writes stay gone
    endtask

    initial begin
        void'($urandom(32'h123f));
        reset_req    = 1'b0;
        ioctl_addr   = '0;
        ioctl_data   = '0;
        ioctl_wr     = 1'b0;
        prom_rd_sel  = '0;
        prom_rd_addr = '0;
        snd_rd_addr  = '0;
        ready_mode   = READY_HIGH;
        got_rd       = 0;
        errors       = 0;
        checks       = 0;
        test_name    = "reset_start";
        @(negedge clk);
        while (reset)
            @(negedge clk);
        check_value(0, prog_valid);
        check_value(1, ioctl_ready);
        main_scroll_lanes();
        map_obj_reorder();
        sound_readback();
        all_prom_selects();
        random_backpressure();
        reset_flush();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hw/rom_load_pkg.sv
hw/prog_bus_if.sv
hw/rom_region_mapper.sv
hw/prog_write_queue.sv
hw/onchip_rom_bank.sv
hw/rom_loader_top.sv
bench/clock_gen.sv
bench/tb_rom_loader.sv

// File: hw/onchip_rom_bank.sv
// On-chip ROM bank: sound ROM and twelve PROMs written by one-hot strobes, async reads
`timescale 1ns/1ps
`default_nettype none

module onchip_rom_bank #(
    parameter int SND_AW = 15
) (
    input  wire                                 clk,
    input  wire rom_load_pkg::prom_sel_t        prom_we,
    input  wire  [14:0]                         prom_addr,
    input  wire  [rom_load_pkg::DATA_W-1:0]     prom_data,
    input  wire  [3:0]                          prom_rd_sel,
    input  wire  [rom_load_pkg::PROM_AW-1:0]    prom_rd_addr,
    output logic [rom_load_pkg::DATA_W-1:0]     prom_rd_data,
    input  wire  [SND_AW-1:0]                   snd_rd_addr,
    output logic [rom_load_pkg::DATA_W-1:0]     snd_rd_data
);

    localparam int NP     = rom_load_pkg::PROM_COUNT;
    localparam int PDEPTH = 2 ** rom_load_pkg::PROM_AW;
    localparam int SDEPTH = 2 ** SND_AW;

    logic [rom_load_pkg::DATA_W-1:0] prom_mem [NP][PDEPTH];
    logic [rom_load_pkg::DATA_W-1:0] snd_mem  [SDEPTH];

    // PROM writes, one array per strobe bit
    always_ff @(posedge clk) begin
        for (int i = 0; i < NP; i++) begin
            if (prom_we[i])
                prom_mem[i][prom_addr[rom_load_pkg::PROM_AW-1:0]] <= prom_data;
        end
    end

    // Sound ROM write, top strobe bit
    always_ff @(posedge clk) begin
        if (prom_we[NP])
            snd_mem[prom_addr[SND_AW-1:0]] <= prom_data;
    end

    // Reads are plain lookups, unused selects return zero
    always_comb begin
        if (prom_rd_sel < 4'(NP))
            prom_rd_data = prom_mem[prom_rd_sel][prom_rd_addr];
        else
            prom_rd_data = '0;
    end

    assign snd_rd_data = snd_mem[snd_rd_addr];

    // Sound offsets from the mapper must fit the array here
    a_snd_fits: assert property (@(posedge clk)
        prom_we[NP] |-> (prom_addr >> SND_AW) == '0);

endmodule

`default_nettype wire

// File: hw/prog_bus_if.sv
// SDRAM programming write bus: one masked byte write with a valid/ready handshake
`timescale 1ns/1ps
`default_nettype none

interface prog_bus_if;

    logic [rom_load_pkg::PROG_AW-1:0] addr;                 // Word address
    logic [rom_load_pkg::DATA_W-1:0]  data;                 // Byte, same on both lanes
    logic [1:0]                       mask;                 // Active low lane enables
    logic                             valid;
    logic                             ready;

    // Producer side, the mapper
    modport src (
        output addr,
        output data,
        output mask,
        output valid,
        input  ready
    );

    // Consumer side, the write queue
    modport dst (
        input  addr,
        input  data,
        input  mask,
        input  valid,
        output ready
    );

endinterface

`default_nettype wire

// File: hw/prog_write_queue.sv
// Programming write queue as a circular FIFO between the mapper and the SDRAM write port
`timescale 1ns/1ps
`default_nettype none

module prog_write_queue #(
    parameter int DEPTH = 4
) (
    input  wire                                 clk,
    input  wire                                 reset,
    prog_bus_if.dst                             in_bus,
    output logic [rom_load_pkg::PROG_AW-1:0]    out_addr,
    output logic [rom_load_pkg::DATA_W-1:0]     out_data,
    output logic [1:0]                          out_mask,
    output logic                                out_valid,
    input  wire                                 out_ready
);

    localparam int W  = rom_load_pkg::PROG_AW + rom_load_pkg::DATA_W + 2;
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;    // Pointer width
    localparam int CW = $clog2(DEPTH + 1);                  // Count up to DEPTH

    logic [W-1:0]  mem [DEPTH];                             // {addr, data, mask}
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [W-1:0]  head;
    logic          wr;
    logic          rd;

    assign in_bus.ready = (count != CW'(DEPTH));            // Not full
    assign out_valid    = (count != '0);
    assign wr           = in_bus.valid && in_bus.ready;
    assign rd           = out_valid && out_ready;

    assign head     = mem[rd_ptr];
    assign out_addr = head[W-1 -: rom_load_pkg::PROG_AW];
    assign out_data = head[2 +: rom_load_pkg::DATA_W];
    assign out_mask = head[1:0];

    always_ff @(posedge clk) begin
        if (wr)
            mem[wr_ptr] <= {in_bus.addr, in_bus.data, in_bus.mask};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr)
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
            if (rd)
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr, rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                    // Both or neither
            endcase
        end
    end

    // A write into a full queue would push the count past DEPTH
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        count <= CW'(DEPTH));

    // Pointers meet whenever the queue is empty
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        count == '0 |-> wr_ptr == rd_ptr);

endmodule

`default_nettype wire

// File: hw/rom_load_pkg.sv
// ROM download package: ROM map constants, region codes, PROM strobe type and address views
`default_nettype none

package rom_load_pkg;

    localparam int ADDR_W  = 22;                            // Download byte address width
    localparam int PROG_AW = 22;                            // SDRAM word address width
    localparam int DATA_W  = 8;                             // One byte per download write

    // ROM map, byte addresses as seen by the downloader
    localparam logic [ADDR_W-1:0] SND_START  = 22'h02_8000; // Sound CPU ROM
    localparam logic [ADDR_W-1:0] CHAR_START = 22'h03_0000; // Char tiles, end of sound
    localparam logic [ADDR_W-1:0] MAP_START  = 22'h03_8000; // Background map
    localparam logic [ADDR_W-1:0] SCR_START  = 22'h04_8000; // Scroll tiles
    localparam logic [ADDR_W-1:0] OBJ_START  = 22'h09_8000; // Sprites
    localparam logic [ADDR_W-1:0] ROM_END    = 22'h0D_8000; // PROMs from here on

    localparam int PROM_COUNT = 12;                         // Colour and timing PROMs
    localparam int PROM_AW    = 8;                          // 256 bytes each

    typedef enum logic [2:0] {
        REG_MAIN,                                           // Main CPU and char, linear
        REG_SOUND,                                          // On-chip sound ROM
        REG_MAP,                                            // Reordered map
        REG_SCR,                                            // Scroll, lane from bit 15
        REG_OBJ,                                            // Reordered sprites
        REG_PROM                                            // On-chip PROMs
    } region_e;

    // Bits 0..11 pick a PROM, bit 12 the sound ROM
    typedef logic [PROM_COUNT:0] prom_sel_t;

    typedef struct packed {
        logic [9:0]         hi;                             // Region bits, not decoded here
        logic [3:0]         sel;                            // PROM number
        logic [PROM_AW-1:0] offset;                         // Byte inside the PROM
    } prom_addr_t;

    typedef union packed {
        logic [ADDR_W-1:0] linear;                          // Raw byte address
        prom_addr_t        prom;                            // PROM region view
    } dl_addr_u;

endpackage

`default_nettype wire

// File: hw/rom_loader_top.sv
// ROM loader top: download bytes into SDRAM writes through a queue, plus on-chip ROMs
`timescale 1ns/1ps
`default_nettype none

module rom_loader_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int SND_AW      = 15
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  wire  [rom_load_pkg::ADDR_W-1:0]     ioctl_addr,     // From the downloader
    input  wire  [rom_load_pkg::DATA_W-1:0]     ioctl_data,
    input  wire                                 ioctl_wr,
    output logic                                ioctl_ready,
    output logic [rom_load_pkg::PROG_AW-1:0]    prog_addr,      // To the SDRAM controller
    output logic [rom_load_pkg::DATA_W-1:0]     prog_data,
    output logic [1:0]                          prog_mask,
    output logic                                prog_valid,
    input  wire                                 prog_ready,
    input  wire  [3:0]                          prom_rd_sel,    // Game side reads
    input  wire  [rom_load_pkg::PROM_AW-1:0]    prom_rd_addr,
    output logic [rom_load_pkg::DATA_W-1:0]     prom_rd_data,
    input  wire  [SND_AW-1:0]                   snd_rd_addr,
    output logic [rom_load_pkg::DATA_W-1:0]     snd_rd_data
);

    prog_bus_if prog_bus ();                                // Mapper to queue

    rom_load_pkg::prom_sel_t         prom_we;
    logic [14:0]                     prom_addr;
    logic [rom_load_pkg::DATA_W-1:0] prom_data;

    rom_region_mapper u_mapper (
        .clk         (clk),
        .reset       (reset),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .ioctl_ready (ioctl_ready),
        .prog        (prog_bus),
        .prom_we     (prom_we),
        .prom_addr   (prom_addr),
        .prom_data   (prom_data)
    );

    prog_write_queue #(
        .DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk       (clk),
        .reset     (reset),
        .in_bus    (prog_bus),
        .out_addr  (prog_addr),
        .out_data  (prog_data),
        .out_mask  (prog_mask),
        .out_valid (prog_valid),
        .out_ready (prog_ready)
    );

    onchip_rom_bank #(
        .SND_AW (SND_AW)
    ) u_rom_bank (
        .clk          (clk),
        .prom_we      (prom_we),
        .prom_addr    (prom_addr),
        .prom_data    (prom_data),
        .prom_rd_sel  (prom_rd_sel),
        .prom_rd_addr (prom_rd_addr),
        .prom_rd_data (prom_rd_data),
        .snd_rd_addr  (snd_rd_addr),
        .snd_rd_data  (snd_rd_data)
    );

endmodule

`default_nettype wire

// File: hw/rom_region_mapper.sv
// ROM region mapper: sorts download bytes into SDRAM writes or on-chip ROM strobes
`timescale 1ns/1ps
`default_nettype none

module rom_region_mapper (
    input  wire                                clk,
    input  wire                                reset,
    input  wire  [rom_load_pkg::ADDR_W-1:0]    ioctl_addr,
    input  wire  [rom_load_pkg::DATA_W-1:0]    ioctl_data,
    input  wire                                ioctl_wr,
    output logic                               ioctl_ready,
    prog_bus_if.src                            prog,
    output rom_load_pkg::prom_sel_t            prom_we,
    output logic [14:0]                        prom_addr,
    output logic [rom_load_pkg::DATA_W-1:0]    prom_data
);

    localparam int AW = rom_load_pkg::ADDR_W;
    localparam int PW = rom_load_pkg::PROG_AW;

    // Word bases of the reordered regions
    localparam logic [PW-1:0] MAP_BASE = PW'(rom_load_pkg::MAP_START >> 1);
    localparam logic [PW-1:0] SCR_BASE = PW'(rom_load_pkg::SCR_START >> 1);

    rom_load_pkg::dl_addr_u  dl_addr;                       // Same address, two views
    rom_load_pkg::region_e   region;
    rom_load_pkg::prom_sel_t strobe;                        // Next on-chip strobe
    logic [AW-1:0]           snd_off;
    logic [AW-1:0]           map_off;
    logic [AW-1:0]           scr_off;                       // Shared by scroll and object
    logic [PW-1:0]           word_addr;
    logic                    lane_hi;                       // Byte goes to the high lane
    logic [14:0]             chip_addr;
    logic                    is_bulk;
    logic                    accept;

    // Free to take a byte unless a write is stuck at the queue
    assign ioctl_ready = !prog.valid || prog.ready;
    assign accept      = ioctl_wr && ioctl_ready;

    always_comb begin
        dl_addr.linear = ioctl_addr;
        snd_off        = ioctl_addr - rom_load_pkg::SND_START;
        map_off        = ioctl_addr - rom_load_pkg::MAP_START;
        scr_off        = ioctl_addr - rom_load_pkg::SCR_START;
    end

    // Region decode, sound sits inside the main/char window
    always_comb begin
        if (dl_addr.linear < rom_load_pkg::MAP_START) begin
            if (dl_addr.linear >= rom_load_pkg::SND_START &&
                dl_addr.linear <  rom_load_pkg::CHAR_START)
                region = rom_load_pkg::REG_SOUND;
            else
                region = rom_load_pkg::REG_MAIN;
        end else if (dl_addr.linear < rom_load_pkg::SCR_START) begin
            region = rom_load_pkg::REG_MAP;
        end else if (dl_addr.linear < rom_load_pkg::OBJ_START) begin
            region = rom_load_pkg::REG_SCR;
        end else if (dl_addr.linear < rom_load_pkg::ROM_END) begin
            region = rom_load_pkg::REG_OBJ;
        end else begin
            region = rom_load_pkg::REG_PROM;
        end
    end

    // Word address, lane and on-chip strobe per region
    always_comb begin
        word_addr = '0;
        lane_hi   = 1'b0;
        strobe    = '0;
        chip_addr = '0;
        is_bulk   = 1'b1;
        case (region)
            rom_load_pkg::REG_MAIN: begin
                word_addr = {1'b0, ioctl_addr[AW-1:1]};     // Plain halving
                lane_hi   = ioctl_addr[0];
            end
            rom_load_pkg::REG_SOUND: begin
                is_bulk   = 1'b0;
                strobe[rom_load_pkg::PROM_COUNT] = 1'b1;    // Sound ROM bit
                chip_addr = snd_off[14:0];
            end
            rom_load_pkg::REG_MAP: begin
                // Bit 4 becomes the lowest word bit so tile rows sit side by side
                word_addr = MAP_BASE + {1'b0, map_off[AW-1:5], map_off[3:1], map_off[4]};
                lane_hi   = map_off[0];
            end
            rom_load_pkg::REG_SCR: begin
                word_addr = SCR_BASE + {1'b0, scr_off[AW-1:16], scr_off[14:0]};
                lane_hi   = scr_off[15];                    // Upper half goes high lane
            end
            rom_load_pkg::REG_OBJ: begin
                // Offset counted from the scroll start, bit 5 moved down
                word_addr = SCR_BASE + {1'b0, scr_off[AW-1:16], scr_off[14:6],
                                        scr_off[4:1], scr_off[5], scr_off[0]};
                lane_hi   = scr_off[15];
            end
            default: begin                                  // PROM region
                is_bulk   = 1'b0;
                chip_addr = {{(15 - rom_load_pkg::PROM_AW){1'b0}}, dl_addr.prom.offset};
                if (dl_addr.prom.sel < 4'(rom_load_pkg::PROM_COUNT))
                    strobe[dl_addr.prom.sel] = 1'b1;        // Selects 12..15 dropped
            end
        endcase
    end

    // Control state
    always_ff @(posedge clk) begin
        if (reset) begin
            prog.valid <= 1'b0;
            prom_we    <= '0;
        end else begin
            prom_we <= '0;                                  // One cycle pulse
            if (prog.valid && prog.ready)
                prog.valid <= 1'b0;                         // Queue took it
            if (accept) begin
                prog.valid <= is_bulk;
                prom_we    <= strobe;
            end
        end
    end

    // Payload, only loaded when a new byte is taken
    always_ff @(posedge clk) begin
        if (accept && is_bulk) begin
            prog.addr <= word_addr;
            prog.data <= ioctl_data;
            prog.mask <= {!lane_hi, lane_hi};               // Enabled lane reads 0
        end
        if (accept && !is_bulk) begin
            prom_addr <= chip_addr;
            prom_data <= ioctl_data;
        end
    end

    a_prom_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(prom_we));

    // A held write keeps its payload until the handshake
    a_prog_stable: assert property (@(posedge clk) disable iff (reset)
        prog.valid && !prog.ready |=>
            prog.valid && $stable({prog.addr, prog.data, prog.mask}));

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build the ROM loader testbench with Verilator, run it and check the log
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_rom_loader -f filelist.f \
    -o sim_rom_loader > build.log 2>&1 \
    && ./obj_dir/sim_rom_loader > sim.log 2>&1
grep -q "^Simulation completed successfully$" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }
